//--- flist.f
source/part_buf_pkg.sv
source/block_addr_cnt.sv
source/block_buffer.sv
source/part_buf_fsm.sv
source/part_buf.sv
test/otp_mem_model.sv
test/tb_part_buf.sv

//--- test/tb_part_buf.sv
// Testbench with clock, reset, OTP model, reference expectations, compare tasks and watchdog

`timescale 1ns/10ps

module tb_part_buf;

  import part_buf_pkg::*;

  // Upper bound on OTP reads over all runs
  localparam int NumReads      = 72;
  localparam int CyclesPerRead = 200;
  localparam part_data_t LockedPattern = {(PartWidth / 8){8'hA5}};

  logic       clk_i;
  logic       rst_ni;
  logic       init_req_i;
  logic       cnsty_chk_req_i;
  logic       escalate_en_i;
  logic       check_byp_en_i;
  logic       read_lock_i;
  logic       write_lock_i;
  logic       init_done_o;
  logic       cnsty_chk_ack_o;
  logic       fsm_err_o;
  logic       read_lock_o;
  logic       write_lock_o;
  otp_err_e   error_o;
  part_data_t data_o;
  // OTP port
  logic       otp_req;
  otp_addr_t  otp_addr;
  logic       otp_gnt;
  logic       otp_rvalid;
  block_t     otp_rdata;
  otp_err_e   otp_err;
  // Model image, injected error and reference state
  part_data_t image;
  part_data_t buf_img;
  cnt_t       err_blk;
  otp_err_e   err_code;
  logic       model_unlocked;

  always #4 clk_i = ~clk_i;

  part_buf u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .init_req_i      (init_req_i),
    .init_done_o     (init_done_o),
    .cnsty_chk_req_i (cnsty_chk_req_i),
    .cnsty_chk_ack_o (cnsty_chk_ack_o),
    .escalate_en_i   (escalate_en_i),
    .check_byp_en_i  (check_byp_en_i),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .read_lock_i     (read_lock_i),
    .write_lock_i    (write_lock_i),
    .read_lock_o     (read_lock_o),
    .write_lock_o    (write_lock_o),
    .data_o          (data_o),
    .otp_req_o       (otp_req),
    .otp_addr_o      (otp_addr),
    .otp_gnt_i       (otp_gnt),
    .otp_rvalid_i    (otp_rvalid),
    .otp_rdata_i     (otp_rdata),
    .otp_err_i       (otp_err)
  );

  otp_mem_model u_otp (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (otp_req),
    .addr_i     (otp_addr),
    .gnt_o      (otp_gnt),
    .rvalid_o   (otp_rvalid),
    .rdata_o    (otp_rdata),
    .err_o      (otp_err),
    .image_i    (image),
    .err_blk_i  (err_blk),
    .err_code_i (err_code)
  );

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_data(input string name, input part_data_t exp, input part_data_t act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic check_err(input string name, input otp_err_e exp, input otp_err_e act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %s got %s", $time, name, exp.name(), act.name());
      $display("Test failed");
      $fatal(1, "Error code mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %b got %b", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "Bit mismatch");
    end
  endtask

  // Data gate and forced locks follow the unlocked state
  task automatic compare_outputs(input otp_err_e exp_err);
    check_data("data_o", model_unlocked ? buf_img : LockedPattern, data_o);
    check_err("error_o", exp_err, error_o);
    check_bit("init_done_o", model_unlocked, init_done_o);
    check_bit("read_lock_o", read_lock_i || !model_unlocked, read_lock_o);
    check_bit("write_lock_o", write_lock_i || !model_unlocked, write_lock_o);
  endtask

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni          <= 1'b0;
    init_req_i      <= 1'b0;
    cnsty_chk_req_i <= 1'b0;
    escalate_en_i   <= 1'b0;
    check_byp_en_i  <= 1'b0;
    read_lock_i     <= 1'b0;
    write_lock_i    <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    model_unlocked = 1'b0;
    @(negedge clk_i);
  endtask

  // Pulse init, return on done or on any latched fatal error
  task automatic run_init();
    @(posedge clk_i);
    init_req_i <= 1'b1;
    @(posedge clk_i);
    init_req_i <= 1'b0;
    @(negedge clk_i);
    while (!init_done_o && ((error_o == NoError) || (error_o == MacroEccCorrError))) begin
      @(negedge clk_i);
    end
  endtask

  task automatic request_check();
    @(posedge clk_i);
    cnsty_chk_req_i <= 1'b1;
    @(posedge clk_i);
    cnsty_chk_req_i <= 1'b0;
  endtask

  task automatic wait_ack();
    @(negedge clk_i);
    while (!cnsty_chk_ack_o) begin
      @(negedge clk_i);
    end
  endtask

  // A passing check answers with exactly one ack cycle
  task automatic verify_clean_check();
    int extra;
    extra = 0;
    request_check();
    wait_ack();
    repeat (4) begin
      @(negedge clk_i);
      if (cnsty_chk_ack_o) begin
        extra++;
      end
    end
    check_bit("cnsty_chk_ack_o repeat", 1'b0, extra != 0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int i;
    int blk_sel;
    int bit_sel;
    void'($urandom(32'h88b6_ee0a));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    init_req_i = 1'b0;
    cnsty_chk_req_i = 1'b0;
    escalate_en_i = 1'b0;
    check_byp_en_i = 1'b0;
    read_lock_i = 1'b0;
    write_lock_i = 1'b0;
    err_blk = '0;
    err_code = NoError;
    model_unlocked = 1'b0;
    for (i = 0; i < PartWidth / 32; i++) begin
      image[i*32 +: 32] = $urandom();
    end
    buf_img = image;

    // Clean init, checks on random locks, then a corrupted word
    apply_reset();
    compare_outputs(NoError);
    // Idle strobes out of reset
    check_bit("otp_req_o", 1'b0, otp_req);
    check_bit("cnsty_chk_ack_o", 1'b0, cnsty_chk_ack_o);
    check_bit("fsm_err_o", 1'b0, fsm_err_o);
    run_init();
    model_unlocked = 1'b1;
    compare_outputs(NoError);
    repeat (4) begin
      @(posedge clk_i);
      read_lock_i  <= 1'($urandom_range(0, 1));
      write_lock_i <= 1'($urandom_range(0, 1));
      verify_clean_check();
      compare_outputs(NoError);
    end
    blk_sel = $urandom_range(0, NumBlocks - 1);
    bit_sel = $urandom_range(0, BlockWidth - 1);
    image[blk_sel*BlockWidth + bit_sel] = ~image[blk_sel*BlockWidth + bit_sel];
    @(posedge clk_i);
    check_byp_en_i <= 1'b1;
    verify_clean_check();
    compare_outputs(NoError);
    @(posedge clk_i);
    check_byp_en_i <= 1'b0;
    request_check();
    wait_ack();
    @(negedge clk_i);
    model_unlocked = 1'b0;
    compare_outputs(CheckFailError);

    // Correctable ECC during init, then escalation from idle
    err_blk  = cnt_t'($urandom_range(0, NumBlocks - 1));
    err_code = MacroEccCorrError;
    apply_reset();
    run_init();
    model_unlocked = 1'b1;
    buf_img = image;
    compare_outputs(MacroEccCorrError);
    @(posedge clk_i);
    escalate_en_i <= 1'b1;
    @(negedge clk_i);
    check_bit("fsm_err_o", 1'b1, fsm_err_o);
    @(posedge clk_i);
    escalate_en_i <= 1'b0;
    @(negedge clk_i);
    check_bit("fsm_err_o", 1'b0, fsm_err_o);
    model_unlocked = 1'b0;
    compare_outputs(FsmStateError);
    request_check();
    @(negedge clk_i);
    check_bit("cnsty_chk_ack_o", 1'b1, cnsty_chk_ack_o);

    // Uncorrectable ECC stops init in the error state
    err_code = MacroEccUncorrError;
    apply_reset();
    run_init();
    compare_outputs(MacroEccUncorrError);

    $display("Test passed");
    $finish;
  end

  // Bounded by the total read count
  initial begin
    repeat (NumReads * CyclesPerRead) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles without finishing", NumReads * CyclesPerRead);
    $display("Test failed");
    $fatal(1, "Timeout");
  end

endmodule

//--- test/otp_mem_model.sv
// Behavioral OTP macro with random grant and response delays and one injectable error block

`timescale 1ns/10ps

module otp_mem_model (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Request side from the partition
  input  logic                     req_i,
  input  part_buf_pkg::otp_addr_t  addr_i,
  output logic                     gnt_o,
  // Response side
  output logic                     rvalid_o,
  output part_buf_pkg::block_t     rdata_o,
  output part_buf_pkg::otp_err_e   err_o,
  // Memory contents, block 0 lowest
  input  part_buf_pkg::part_data_t image_i,
  // Error code returned for every read of one block
  input  part_buf_pkg::cnt_t       err_blk_i,
  input  part_buf_pkg::otp_err_e   err_code_i
);

  import part_buf_pkg::*;

  logic        busy_q;
  int unsigned gnt_dly_q;
  int unsigned rsp_dly_q;
  cnt_t        blk_q;
  cnt_t        blk;

  // Halfword address back to a block index, four halfwords per block
  assign blk = cnt_t'((addr_i - otp_addr_t'(PartOffset >> OtpAddrShift)) / (BlockWidth / 16));

  ////////////////////
  // Grant and response
  ////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      gnt_dly_q <= 0;
      rsp_dly_q <= 0;
      blk_q     <= '0;
      gnt_o     <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      err_o     <= NoError;
    end else begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      if (busy_q) begin
        // One read outstanding, answer after the drawn delay
        if (rsp_dly_q == 0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= image_i[blk_q*BlockWidth +: BlockWidth];
          err_o    <= (blk_q == err_blk_i) ? err_code_i : NoError;
          busy_q   <= 1'b0;
        end else begin
          rsp_dly_q <= rsp_dly_q - 1;
        end
      end else if (req_i) begin
        // Withheld grant while the delay runs down
        if (gnt_dly_q == 0) begin
          gnt_o     <= 1'b1;
          busy_q    <= 1'b1;
          blk_q     <= blk;
          rsp_dly_q <= $urandom_range(0, 3);
          gnt_dly_q <= $urandom_range(0, 3);
        end else begin
          gnt_dly_q <= gnt_dly_q - 1;
        end
      end
    end
  end

endmodule

//--- source/part_buf.sv
// Buffered OTP partition top level with FSM, block counter and buffer registers

`timescale 1ns/10ps

module part_buf (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Initialization
  input  logic                     init_req_i,
  output logic                     init_done_o,
  // Consistency check
  input  logic                     cnsty_chk_req_i,
  output logic                     cnsty_chk_ack_o,
  // Escalation and check bypass levels
  input  logic                     escalate_en_i,
  input  logic                     check_byp_en_i,
  // Partition status
  output part_buf_pkg::otp_err_e   error_o,
  output logic                     fsm_err_o,
  // Access locks
  input  logic                     read_lock_i,
  input  logic                     write_lock_i,
  output logic                     read_lock_o,
  output logic                     write_lock_o,
  // Buffered partition contents
  output part_buf_pkg::part_data_t data_o,
  // OTP macro port
  output logic                     otp_req_o,
  output part_buf_pkg::otp_addr_t  otp_addr_o,
  input  logic                     otp_gnt_i,
  input  logic                     otp_rvalid_i,
  input  part_buf_pkg::block_t     otp_rdata_i,
  input  part_buf_pkg::otp_err_e   otp_err_i
);

  import part_buf_pkg::*;

  // FSM to counter
  logic cnt_clr;
  logic cnt_en;
  // Counter back to FSM and buffer
  cnt_t cnt;
  logic cnt_last;
  logic cnt_err;
  // FSM and buffer
  logic buf_wr_en;
  logic buf_match;
  logic unlocked;

  ////////////////////
  // Control
  ////////////////////

  part_buf_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .init_req_i      (init_req_i),
    .cnsty_chk_req_i (cnsty_chk_req_i),
    .escalate_en_i   (escalate_en_i),
    .check_byp_en_i  (check_byp_en_i),
    .read_lock_i     (read_lock_i),
    .write_lock_i    (write_lock_i),
    .otp_gnt_i       (otp_gnt_i),
    .otp_rvalid_i    (otp_rvalid_i),
    .otp_err_i       (otp_err_i),
    .last_i          (cnt_last),
    .cnt_err_i       (cnt_err),
    .match_i         (buf_match),
    .otp_req_o       (otp_req_o),
    .cnt_clr_o       (cnt_clr),
    .cnt_en_o        (cnt_en),
    .buf_wr_en_o     (buf_wr_en),
    .unlocked_o      (unlocked),
    .init_done_o     (init_done_o),
    .cnsty_chk_ack_o (cnsty_chk_ack_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .read_lock_o     (read_lock_o),
    .write_lock_o    (write_lock_o)
  );

  ////////////////////
  // Datapath
  ////////////////////

  // Block index and macro address
  block_addr_cnt u_cnt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clr_i      (cnt_clr),
    .en_i       (cnt_en),
    .cnt_o      (cnt),
    .last_o     (cnt_last),
    .err_o      (cnt_err),
    .otp_addr_o (otp_addr_o)
  );

  // Read data goes straight into the buffer and the compare
  block_buffer u_buffer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_en_i    (buf_wr_en),
    .idx_i      (cnt),
    .wdata_i    (otp_rdata_i),
    .unlocked_i (unlocked),
    .match_o    (buf_match),
    .data_o     (data_o)
  );

endmodule

//--- source/part_buf_fsm.sv
// Partition FSM for initialization, consistency checks, error latching and locking

`timescale 1ns/10ps

module part_buf_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Control pulses and levels
  input  logic                   init_req_i,
  input  logic                   cnsty_chk_req_i,
  input  logic                   escalate_en_i,
  input  logic                   check_byp_en_i,
  // Incoming access locks
  input  logic                   read_lock_i,
  input  logic                   write_lock_i,
  // OTP response side
  input  logic                   otp_gnt_i,
  input  logic                   otp_rvalid_i,
  input  part_buf_pkg::otp_err_e otp_err_i,
  // Counter and buffer status
  input  logic                   last_i,
  input  logic                   cnt_err_i,
  input  logic                   match_i,
  // OTP request
  output logic                   otp_req_o,
  // Counter and buffer control
  output logic                   cnt_clr_o,
  output logic                   cnt_en_o,
  output logic                   buf_wr_en_o,
  output logic                   unlocked_o,
  // Status
  output logic                   init_done_o,
  output logic                   cnsty_chk_ack_o,
  output part_buf_pkg::otp_err_e error_o,
  output logic                   fsm_err_o,
  // Outgoing access locks
  output logic                   read_lock_o,
  output logic                   write_lock_o
);

  import part_buf_pkg::*;

  state_e   state_d, state_q;
  otp_err_e error_d, error_q;
  logic     unlocked_d, unlocked_q;
  logic     rsp_ok;

  // Correctable ECC still counts as a usable word
  assign rsp_ok = (otp_err_i == NoError) || (otp_err_i == MacroEccCorrError);

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d    = state_q;
    error_d    = error_q;
    unlocked_d = unlocked_q;

    otp_req_o       = 1'b0;
    cnt_clr_o       = 1'b0;
    cnt_en_o        = 1'b0;
    buf_wr_en_o     = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    fsm_err_o       = 1'b0;

    unique case (state_q)
      // Wait for the one-time init pulse
      ResetSt: begin
        if (init_req_i) begin
          cnt_clr_o = 1'b1;
          state_d   = InitSt;
        end
      end

      // Hold request and address until granted
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end

      // Store the word, then next block or unlock
      InitWaitSt: begin
        if (otp_rvalid_i) begin
          if (rsp_ok) begin
            buf_wr_en_o = 1'b1;
            if (last_i) begin
              unlocked_d = 1'b1;
              state_d    = IdleSt;
            end else begin
              cnt_en_o = 1'b1;
              state_d  = InitSt;
            end
            // Record the correctable error, keep going
            if (otp_err_i != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            error_d = otp_err_i;
            state_d = ErrorSt;
          end
        end
      end

      // Only consistency checks start from here
      IdleSt: begin
        if (cnsty_chk_req_i) begin
          cnt_clr_o = 1'b1;
          state_d   = CnstyReadSt;
        end
      end

      CnstyReadSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = CnstyReadWaitSt;
        end
      end

      // Compare the re-read word with the buffered copy
      CnstyReadWaitSt: begin
        if (otp_rvalid_i) begin
          if (rsp_ok) begin
            if (otp_err_i != NoError) begin
              error_d = MacroEccCorrError;
            end
            if (match_i || check_byp_en_i) begin
              if (last_i) begin
                cnsty_chk_ack_o = 1'b1;
                state_d         = IdleSt;
              end else begin
                cnt_en_o = 1'b1;
                state_d  = CnstyReadSt;
              end
            end else begin
              // Miscompare overrides a correctable error
              error_d         = CheckFailError;
              cnsty_chk_ack_o = 1'b1;
              state_d         = ErrorSt;
            end
          end else begin
            error_d         = otp_err_i;
            cnsty_chk_ack_o = 1'b1;
            state_d         = ErrorSt;
          end
        end
      end

      // Terminal, checks are answered at once
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
        cnsty_chk_ack_o = 1'b1;
      end

      default: begin
        fsm_err_o = 1'b1;
        state_d   = ErrorSt;
      end
    endcase

    // Escalation or counter overrun from any state
    if (escalate_en_i || cnt_err_i) begin
      fsm_err_o = 1'b1;
      state_d   = ErrorSt;
      if (state_q != ErrorSt) begin
        error_d = FsmStateError;
      end
    end

    // Entering or staying in error relocks the data
    if (state_d == ErrorSt) begin
      unlocked_d = 1'b0;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ResetSt;
      error_q    <= NoError;
      unlocked_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      error_q    <= error_d;
      unlocked_q <= unlocked_d;
    end
  end

  assign error_o     = error_q;
  assign unlocked_o  = unlocked_q;
  assign init_done_o = unlocked_q;

  // Locked partition forces both locks on
  assign read_lock_o  = read_lock_i  || !unlocked_q;
  assign write_lock_o = write_lock_i || !unlocked_q;

endmodule

//--- source/block_buffer.sv
// Buffer register file with block write port, read-back compare and gated partition output

`timescale 1ns/10ps

module block_buffer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Write port, indexed by the block counter
  input  logic                     wr_en_i,
  input  part_buf_pkg::cnt_t       idx_i,
  // OTP read data, used both as write data and compare value
  input  part_buf_pkg::block_t     wdata_i,
  // Output gate from the FSM
  input  logic                     unlocked_i,
  // Read-back compare result
  output logic                     match_o,
  // Whole partition, block 0 in the lowest bits
  output part_buf_pkg::part_data_t data_o
);

  import part_buf_pkg::*;

  // Packed so that the concatenation falls out directly
  block_t [NumBlocks-1:0] mem_q;
  block_t                 rd_block;
  part_data_t             data_raw;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (wr_en_i) begin
      mem_q[idx_i] <= wdata_i;
    end
  end

  ////////////////////
  // Compare
  ////////////////////

  // Block selected by the counter
  assign rd_block = mem_q[idx_i];

  // Fresh OTP word against the buffered copy
  assign match_o = (rd_block == wdata_i);

  ////////////////////
  // Output gating
  ////////////////////

  assign data_raw = mem_q;

  // Buffered data is only visible while unlocked
  always_comb begin
    if (unlocked_i) begin
      data_o = data_raw;
    end else begin
      data_o = DataDefault;
    end
  end

endmodule

//--- source/block_addr_cnt.sv
// Block index counter with last-block flag, overrun error and OTP halfword address

`timescale 1ns/10ps

module block_addr_cnt (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Counter control from the FSM
  input  logic                  clr_i,
  input  logic                  en_i,
  // Current block and status
  output part_buf_pkg::cnt_t    cnt_o,
  output logic                  last_o,
  output logic                  err_o,
  // Address of the current block
  output part_buf_pkg::otp_addr_t otp_addr_o
);

  import part_buf_pkg::*;

  localparam cnt_t LastBlock = cnt_t'(NumBlocks - 1);

  cnt_t cnt_q;
  logic err_q;
  logic [ByteAddrWidth-1:0] addr_calc;

  ////////////////////
  // Counter
  ////////////////////

  // Clear wins over increment
  // Holds at the last block instead of wrapping
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      err_q <= 1'b0;
    end else begin
      err_q <= en_i && !clr_i && (cnt_q == LastBlock);
      if (clr_i) begin
        cnt_q <= '0;
      end else if (en_i && (cnt_q != LastBlock)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign cnt_o  = cnt_q;
  assign last_o = (cnt_q == LastBlock);
  // One-cycle pulse after an increment past the end
  assign err_o  = err_q;

  ////////////////////
  // Address
  ////////////////////

  // Eight bytes per block, then drop the halfword bit
  assign addr_calc  = ByteAddrWidth'({cnt_q, 3'b000}) + PartOffset;
  assign otp_addr_o = addr_calc[ByteAddrWidth-1:OtpAddrShift];

endmodule

//--- source/part_buf_pkg.sv
// Partition geometry, vector types, error codes and state encoding for the buffered partition

package part_buf_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  // One block is one OTP read
  localparam int BlockWidth = 64;
  localparam int NumBlocks  = 8;
  localparam int CntWidth   = 3;

  // Partition location in the OTP byte space
  localparam int ByteAddrWidth = 12;
  localparam logic [ByteAddrWidth-1:0] PartOffset = 12'h040;

  // Macro works on 16 bit halfwords
  localparam int OtpAddrShift = 1;
  localparam int OtpAddrWidth = ByteAddrWidth - OtpAddrShift;

  // Whole partition width in bits
  localparam int PartWidth = BlockWidth * NumBlocks;

  // Shown on the data output while the partition is locked
  localparam logic [PartWidth-1:0] DataDefault = {(PartWidth / 8){8'hA5}};

  ////////////////////
  // Types
  ////////////////////

  typedef logic [BlockWidth-1:0]   block_t;
  typedef logic [CntWidth-1:0]     cnt_t;
  typedef logic [OtpAddrWidth-1:0] otp_addr_t;
  typedef logic [PartWidth-1:0]    part_data_t;

  // Error codes, shared by the macro response and the partition status
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    CheckFailError      = 3'h4,
    FsmStateError       = 3'h5
  } otp_err_e;

  // Partition FSM states, plain binary
  typedef enum logic [3:0] {
    ResetSt         = 4'h0,
    InitSt          = 4'h1,
    InitWaitSt      = 4'h2,
    IdleSt          = 4'h3,
    CnstyReadSt     = 4'h4,
    CnstyReadWaitSt = 4'h5,
    ErrorSt         = 4'h6
  } state_e;

endpackage
